/* sources.f */
+incdir+tests
verilog/mult_pkg.sv
verilog/int_mac.sv
verilog/short_mult.sv
verilog/mulh_ctrl.sv
verilog/simd_dot.sv
verilog/mult_unit.sv
tests/tb_mult_unit.sv

/* tests/mult_tests.svh */
// directed tests of the multiplier and their reference models
`ifndef MULT_TESTS_SVH
`define MULT_TESTS_SVH

  //////////////////////////////
  // reference models
  //////////////////////////////

  // selected halves multiplied, c added, optional rounding, then shifted by imm
  function automatic logic [31:0] subword_ref(mult_req_t r);
    longint      pa;
    longint      pb;
    logic [31:0] sum;
    pa = r.short_subword ? r.op_a[31:16] : r.op_a[15:0];
    pb = r.short_subword ? r.op_b[31:16] : r.op_b[15:0];
    if (r.short_signed[0] && pa[15]) pa = pa - 65536;
    if (r.short_signed[1] && pb[15]) pb = pb - 65536;
    sum = r.op_c + 32'(pa * pb);
    if (r.op == MUL_IR && r.imm != 0) sum = sum + (32'd1 << (r.imm - 1));
    // arithmetic shift only when a is signed
    return r.short_signed[0] ? 32'($signed(sum) >>> r.imm) : sum >> r.imm;
  endfunction

  // upper word of the 64-bit product, each operand extended on its own
  function automatic logic [31:0] mulh_ref(mult_req_t r);
    logic [63:0] xa;
    logic [63:0] xb;
    logic [63:0] p;
    xa = {{32{r.short_signed[0] & r.op_a[31]}}, r.op_a};
    xb = {{32{r.short_signed[1] & r.op_b[31]}}, r.op_b};
    p  = xa * xb;
    return p[63:32];
  endfunction

  // c plus the products of matching lanes of width w
  function automatic logic [31:0] dot_ref(mult_req_t r, int w);
    logic [31:0] acc;
    longint      la;
    longint      lb;
    acc = r.op_c;
    for (int i = 0; i < 32 / w; i++) begin
      la = (r.op_a >> (i * w)) & ((32'd1 << w) - 1);
      lb = (r.op_b >> (i * w)) & ((32'd1 << w) - 1);
      if (r.dot_signed[1] && la[w-1]) la = la - (longint'(1) << w);
      if (r.dot_signed[0] && lb[w-1]) lb = lb - (longint'(1) << w);
      acc = acc + 32'(la * lb);
    end
    return acc;
  endfunction

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic reset_values();
    check_eq("valid_o after reset", 32'd0, 32'(valid_o));
    check_eq("ready_o after reset", 32'd1, 32'(ready_o));
    report_test("reset");
  endtask

  task automatic integer_mac();
    mult_req_t r;
    for (int i = 0; i < 8; i++) begin
      r = rand_req(i[0] ? MUL_MSU32 : MUL_MAC32);
      run_op(i[0] ? "msu" : "mac", r,
             i[0] ? r.op_c - r.op_a * r.op_b : r.op_c + r.op_a * r.op_b);
    end
    report_test("integer mac");
  endtask

  task automatic subword_mult();
    mult_req_t r;
    for (int i = 0; i < 12; i++) begin
      r = rand_req(i[0] ? MUL_IR : MUL_I);
      run_op(i[0] ? "mul_ir" : "mul_i", r, subword_ref(r));
    end
    report_test("subword mult");
  endtask

  task automatic high_half_mult();
    logic [1:0] modes [3] = '{2'b11, 2'b01, 2'b00};
    mult_req_t  r;
    for (int i = 0; i < 12; i++) begin
      r = rand_req(MUL_H);
      r.short_signed = modes[i % 3];
      // extreme operands push carries through every step
      if (i < 3) {r.op_a, r.op_b} = {32'hffff_ffff, 32'h8000_0001};
      run_op("mulh", r, mulh_ref(r));
    end
    report_test("high-half mult");
  endtask

  task automatic dot_products();
    mult_op_e  ops [4] = '{MUL_DOT16, MUL_DOT8, MUL_DOT4, MUL_DOT2};
    mult_req_t r;
    for (int i = 0; i < 16; i++) begin
      r = rand_req(ops[i / 4]);
      r.dot_signed = 2'(i);
      run_op("dot", r, dot_ref(r, 16 >> (i / 4)));
    end
    report_test("dot products");
  endtask

  // a MUL_H and a MAC back to back while the result side stalls
  task automatic back_pressure();
    mult_req_t   rh;
    mult_req_t   rm;
    logic [31:0] held;
    logic [31:0] res;
    rh = rand_req(MUL_H);
    rh.short_signed = 2'b11;
    rm = rand_req(MUL_MAC32);
    ready_i = 1'b0;
    send_req(rh);
    fork
      send_req(rm);
      begin
        wait_valid();
        held = result_o;
        repeat (3) begin
          @(negedge clk);
          check_eq("result held under stall", held, result_o);
          check_eq("ready_o low under stall", 32'd0, 32'(ready_o));
        end
        ready_i = 1'b1;
        get_result(res);
        check_eq("mulh after stall", mulh_ref(rh), res);
        get_result(res);
        check_eq("mac after stall", rm.op_c + rm.op_a * rm.op_b, res);
      end
    join
    report_test("back pressure");
  endtask

`endif

/* tests/tb_mult_unit.sv */
// testbench top with clock, reset, DUT, LFSR, checker, handshake drivers and test sequence

module tb_mult_unit;
  timeunit 1ns;
  timeprecision 1ps;
  import mult_pkg::*;

  localparam int TIMEOUT = 60;

  logic              clk = 1'b0;
  logic              rst_n = 1'b0;
  mult_req_t         req_i = '0;
  logic              valid_i = 1'b0;
  logic              ready_o;
  logic [DATA_W-1:0] result_o;
  logic              valid_o;
  logic              ready_i = 1'b1;
  logic [31:0]       lfsr = 32'd84312;
  int                errors = 0;
  int                checks = 0;
  int                tests = 0;
  int                mark = 0;

  always #5 clk = ~clk;

  mult_unit u_mult_unit (.*);

  //////////////////////////////
  // stimulus and checking
  //////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic mult_req_t rand_req(mult_op_e op);
    mult_req_t r;
    r.op_a = rand_bits(32);
    r.op_b = rand_bits(32);
    r.op_c = rand_bits(32);
    {r.short_subword, r.short_signed, r.dot_signed, r.imm} = 10'(rand_bits(10));
    r.op = op;
    return r;
  endfunction

  task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_test(string name);
    tests++;
    $display("test %s finished with %0d errors", name, errors - mark);
    mark = errors;
  endtask

  // request stays on the bus up to the edge that accepts it
  task automatic send_req(mult_req_t r);
    int n;
    n = 0;
    @(negedge clk);
    req_i   = r;
    valid_i = 1'b1;
    #1;
    while (!ready_o && n < TIMEOUT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!ready_o) begin
      errors++;
      $display("timeout: ready_o stayed low and the request was not accepted");
    end
    @(negedge clk);
    valid_i = 1'b0;
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    while (!valid_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!valid_o) begin
      errors++;
      $display("timeout: valid_o never rose and no result came back");
    end
  endtask

  // ready_i is high here so the result is taken at the next edge
  task automatic get_result(output logic [31:0] res);
    wait_valid();
    res = result_o;
    @(negedge clk);
  endtask

  task automatic run_op(string name, mult_req_t r, logic [31:0] exp);
    logic [31:0] res;
    send_req(r);
    get_result(res);
    check_eq(name, exp, res);
  endtask

  `include "mult_tests.svh"

  initial begin
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_values();
    integer_mac();
    subword_mult();
    high_half_mult();
    dot_products();
    back_pressure();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verilog/int_mac.sv */
// 32-bit multiply-accumulate and multiply-subtract, low word of the result

module int_mac (
  input  logic [mult_pkg::DATA_W-1:0] op_a_i,
  input  logic [mult_pkg::DATA_W-1:0] op_b_i,
  input  logic [mult_pkg::DATA_W-1:0] op_c_i,
  input  logic                        msu_i,
  output logic [mult_pkg::DATA_W-1:0] result_o
);
  import mult_pkg::*;

  logic [DATA_W-1:0] op_a_msu;
  logic [DATA_W-1:0] op_b_corr;

  // c - a*b = c + (~a)*b + b, so one multiplier serves both ops
  assign op_a_msu  = op_a_i ^ {DATA_W{msu_i}};
  assign op_b_corr = op_b_i & {DATA_W{msu_i}};

  // low word only, signedness does not matter modulo 2^32
  assign result_o = op_c_i + op_b_corr + op_a_msu * op_b_i;

endmodule

/* verilog/mulh_ctrl.sv */
// step sequencer and carry register for the multicycle high-half multiply

module mulh_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start_i,
  input  logic [1:0]                  signed_i,
  input  logic [mult_pkg::DATA_W+1:0] mac_i,
  input  logic                        out_free_i,
  output mult_pkg::short_ctrl_t       ctrl_o,
  output logic                        active_o,
  output logic                        carry_o,
  output logic                        finish_o
);
  import mult_pkg::*;

  mulh_state_e state_q;
  mulh_state_e state_d;
  logic        carry_q;
  logic        save_carry;

  //////////////////////////////
  // step decode
  //////////////////////////////

  always_comb begin
    state_d            = state_q;
    ctrl_o.imm         = '0;
    ctrl_o.subword     = 2'b00;
    ctrl_o.signed_ab   = 2'b00;
    ctrl_o.shift_arith = 1'b0;
    ctrl_o.carry_en    = 1'b1;
    active_o           = 1'b1;
    finish_o           = 1'b0;
    save_carry         = 1'b0;

    case (state_q)
      IDLE: begin
        active_o        = 1'b0;
        ctrl_o.carry_en = 1'b0;
        if (start_i) begin
          state_d = STEP0;
        end
      end
      STEP0: begin
        // al*bl is unsigned and fits in 32 bits, keep its upper half
        ctrl_o.imm = IMM_W'(HALF_W);
        state_d    = STEP1;
      end
      STEP1: begin
        // al*bh, signed when b is; the 33-bit sum keeps bit 32 as carry
        ctrl_o.signed_ab   = {signed_i[1], 1'b0};
        ctrl_o.subword     = 2'b10;
        ctrl_o.shift_arith = 1'b1;
        save_carry         = 1'b1;
        state_d            = STEP2;
      end
      STEP2: begin
        // ah*bl, signed when a is; the shift drops bits 33:32 again
        ctrl_o.signed_ab   = {1'b0, signed_i[0]};
        ctrl_o.subword     = 2'b01;
        ctrl_o.imm         = IMM_W'(HALF_W);
        ctrl_o.shift_arith = 1'b1;
        state_d            = FINISH;
      end
      FINISH: begin
        // ah*bh plus the running sum gives the high word
        ctrl_o.signed_ab = signed_i;
        ctrl_o.subword   = 2'b11;
        finish_o         = 1'b1;
        if (out_free_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////
  // state and carry
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // carry lives for one step only
      if (save_carry) begin
        carry_q <= mac_i[DATA_W];
      end else begin
        carry_q <= 1'b0;
      end
    end
  end

  assign carry_o = carry_q;

  a_state_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    state_q inside {IDLE, STEP0, STEP1, STEP2, FINISH}
  ) else $error("mulh sequencer in an undefined state");

endmodule

/* verilog/mult_pkg.sv */
// shared widths, opcode and sequencer state enums, request and subword control structs

package mult_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // operand and result width
  localparam int DATA_W = 32;
  // subword width for the 16x16 datapath
  localparam int HALF_W = 16;
  // shift immediate width
  localparam int IMM_W  = 5;

  //////////////////////////////
  // enums
  //////////////////////////////

  // multiplier operations
  typedef enum logic [3:0] {
    MUL_MAC32,
    MUL_MSU32,
    MUL_I,
    MUL_IR,
    MUL_H,
    MUL_DOT16,
    MUL_DOT8,
    MUL_DOT4,
    MUL_DOT2
  } mult_op_e;

  // high-half multiply step sequence
  typedef enum logic [2:0] {
    IDLE,
    STEP0,
    STEP1,
    STEP2,
    FINISH
  } mulh_state_e;

  //////////////////////////////
  // structs
  //////////////////////////////

  // one request as seen on the input handshake
  typedef struct packed {
    mult_op_e          op;
    // upper half-words for the subword ops
    logic              short_subword;
    // bit 0 for a, bit 1 for b
    logic [1:0]        short_signed;
    // bit 1 for a, bit 0 for b
    logic [1:0]        dot_signed;
    logic [IMM_W-1:0]  imm;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] op_c;
  } mult_req_t;

  // controls of the 16x16 subword datapath
  typedef struct packed {
    logic [IMM_W-1:0] imm;
    // bit 0 picks the a half, bit 1 the b half
    logic [1:0]       subword;
    // bit 0 for a, bit 1 for b
    logic [1:0]       signed_ab;
    logic             shift_arith;
    // accumulator gets the saved carry as its top bit
    logic             carry_en;
  } short_ctrl_t;

endpackage

/* verilog/mult_unit.sv */
// multiplier top level with handshakes, request hold, operand steering, result mux and register

module mult_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  input  mult_pkg::mult_req_t         req_i,
  input  logic                        valid_i,
  output logic                        ready_o,
  output logic [mult_pkg::DATA_W-1:0] result_o,
  output logic                        valid_o,
  input  logic                        ready_i
);
  import mult_pkg::*;

  mult_req_t         req_q;
  logic              accept;
  logic              out_free;
  logic              mulh_start;
  logic              mulh_active;
  logic              mulh_carry;
  logic              mulh_finish;
  short_ctrl_t       mulh_ctrl_s;
  short_ctrl_t       req_ctrl;
  short_ctrl_t       short_ctrl;
  logic [DATA_W-1:0] short_op_a;
  logic [DATA_W-1:0] short_op_b;
  logic [DATA_W-1:0] short_op_c;
  logic              short_round;
  logic [DATA_W+1:0] short_mac;
  logic [DATA_W-1:0] short_res;
  logic [DATA_W-1:0] mac_res;
  logic [DATA_W-1:0] dot16_res;
  logic [DATA_W-1:0] dot8_res;
  logic [DATA_W-1:0] dot4_res;
  logic [DATA_W-1:0] dot2_res;
  logic [DATA_W-1:0] single_res;
  logic [DATA_W-1:0] result_d;
  logic [DATA_W-1:0] result_q;
  logic              load_single;
  logic              load_final;
  logic              load_res;
  logic              valid_q;

  //////////////////////////////
  // handshakes
  //////////////////////////////

  assign out_free   = ~valid_q | ready_i;
  assign ready_o    = ~mulh_active & out_free;
  assign accept     = valid_i & ready_o;
  assign mulh_start = accept & (req_i.op == MUL_H);

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  //////////////////////////////
  // datapaths
  //////////////////////////////

  int_mac u_int_mac (
    .op_a_i   (req_i.op_a),
    .op_b_i   (req_i.op_b),
    .op_c_i   (req_i.op_c),
    .msu_i    (req_i.op == MUL_MSU32),
    .result_o (mac_res)
  );

  // subword controls for MUL_I and MUL_IR
  assign req_ctrl.imm         = req_i.imm;
  assign req_ctrl.subword     = {2{req_i.short_subword}};
  assign req_ctrl.signed_ab   = req_i.short_signed;
  assign req_ctrl.shift_arith = req_i.short_signed[0];
  assign req_ctrl.carry_en    = 1'b0;

  // a running high-half multiply owns the subword datapath;
  // its partial sum lives in the result register until FINISH
  assign short_ctrl  = mulh_active ? mulh_ctrl_s : req_ctrl;
  assign short_op_a  = mulh_active ? req_q.op_a : req_i.op_a;
  assign short_op_b  = mulh_active ? req_q.op_b : req_i.op_b;
  assign short_op_c  = mulh_active ? result_q : req_i.op_c;
  assign short_round = ~mulh_active & (req_i.op == MUL_IR);

  short_mult u_short_mult (
    .op_a_i   (short_op_a),
    .op_b_i   (short_op_b),
    .op_c_i   (short_op_c),
    .ctrl_i   (short_ctrl),
    .carry_i  (mulh_carry),
    .round_i  (short_round),
    .mac_o    (short_mac),
    .result_o (short_res)
  );

  mulh_ctrl u_mulh_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (mulh_start),
    .signed_i   (req_q.short_signed),
    .mac_i      (short_mac),
    .out_free_i (out_free),
    .ctrl_o     (mulh_ctrl_s),
    .active_o   (mulh_active),
    .carry_o    (mulh_carry),
    .finish_o   (mulh_finish)
  );

  simd_dot #(.LANE_W(16)) u_dot16 (
    .op_a_i (req_i.op_a), .op_b_i (req_i.op_b), .op_c_i (req_i.op_c),
    .signed_i (req_i.dot_signed), .result_o (dot16_res)
  );

  simd_dot #(.LANE_W(8)) u_dot8 (
    .op_a_i (req_i.op_a), .op_b_i (req_i.op_b), .op_c_i (req_i.op_c),
    .signed_i (req_i.dot_signed), .result_o (dot8_res)
  );

  simd_dot #(.LANE_W(4)) u_dot4 (
    .op_a_i (req_i.op_a), .op_b_i (req_i.op_b), .op_c_i (req_i.op_c),
    .signed_i (req_i.dot_signed), .result_o (dot4_res)
  );

  simd_dot #(.LANE_W(2)) u_dot2 (
    .op_a_i (req_i.op_a), .op_b_i (req_i.op_b), .op_c_i (req_i.op_c),
    .signed_i (req_i.dot_signed), .result_o (dot2_res)
  );

  //////////////////////////////
  // result mux and register
  //////////////////////////////

  always_comb begin
    case (req_i.op)
      MUL_MAC32, MUL_MSU32: single_res = mac_res;
      MUL_I, MUL_IR:        single_res = short_res;
      MUL_DOT16:            single_res = dot16_res;
      MUL_DOT8:             single_res = dot8_res;
      MUL_DOT4:             single_res = dot4_res;
      MUL_DOT2:             single_res = dot2_res;
      // MUL_H starts from a zero partial sum
      default:              single_res = '0;
    endcase
  end

  assign result_d    = mulh_active ? short_res : single_res;
  assign load_single = accept & (req_i.op != MUL_H);
  assign load_final  = mulh_finish & out_free;
  assign load_res    = accept | (mulh_active & ~mulh_finish) | load_final;

  always_ff @(posedge clk) begin
    if (load_res) begin
      result_q <= result_d;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load_single || load_final) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  assign result_o = result_q;
  assign valid_o  = valid_q;

  //////////////////////////////
  // assertions
  //////////////////////////////

  logic [2*DATA_W-1:0] ref_ss;
  logic [2*DATA_W-1:0] ref_su;
  logic [2*DATA_W-1:0] ref_uu;

  // full products of the held operands, modulo 2^64
  assign ref_ss = {{DATA_W{req_q.op_a[DATA_W-1]}}, req_q.op_a} *
                  {{DATA_W{req_q.op_b[DATA_W-1]}}, req_q.op_b};
  assign ref_su = {{DATA_W{req_q.op_a[DATA_W-1]}}, req_q.op_a} * {{DATA_W{1'b0}}, req_q.op_b};
  assign ref_uu = {{DATA_W{1'b0}}, req_q.op_a} * {{DATA_W{1'b0}}, req_q.op_b};

  a_mulh_ss: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mulh_finish && req_q.short_signed == 2'b11) |-> (short_res == ref_ss[2*DATA_W-1:DATA_W])
  ) else $error("mulh signed x signed high word mismatch");

  a_mulh_su: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mulh_finish && req_q.short_signed == 2'b01) |-> (short_res == ref_su[2*DATA_W-1:DATA_W])
  ) else $error("mulhsu high word mismatch");

  a_mulh_uu: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mulh_finish && req_q.short_signed == 2'b00) |-> (short_res == ref_uu[2*DATA_W-1:DATA_W])
  ) else $error("mulhu high word mismatch");

  a_result_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (valid_o && !ready_i) |=> (valid_o && $stable(result_o))
  ) else $error("result changed under back-pressure");

endmodule

/* verilog/short_mult.sv */
// 16x16 subword multiply with carry-extended accumulator, rounding and immediate shift

module short_mult (
  input  logic [mult_pkg::DATA_W-1:0] op_a_i,
  input  logic [mult_pkg::DATA_W-1:0] op_b_i,
  input  logic [mult_pkg::DATA_W-1:0] op_c_i,
  input  mult_pkg::short_ctrl_t       ctrl_i,
  input  logic                        carry_i,
  input  logic                        round_i,
  output logic [mult_pkg::DATA_W+1:0] mac_o,
  output logic [mult_pkg::DATA_W-1:0] result_o
);
  import mult_pkg::*;

  logic [HALF_W:0]   half_a;
  logic [HALF_W:0]   half_b;
  logic [DATA_W:0]   acc;
  logic [DATA_W+1:0] prod;
  logic [DATA_W-1:0] round_bit;
  logic [DATA_W-1:0] round_val;
  logic              msb_hi;
  logic              msb_lo;
  logic [DATA_W+1:0] shift_in;
  logic [DATA_W+1:0] shifted;

  //////////////////////////////
  // operand selection
  //////////////////////////////

  assign half_a[HALF_W-1:0] = ctrl_i.subword[0] ? op_a_i[DATA_W-1:HALF_W] : op_a_i[HALF_W-1:0];
  assign half_b[HALF_W-1:0] = ctrl_i.subword[1] ? op_b_i[DATA_W-1:HALF_W] : op_b_i[HALF_W-1:0];

  // 17th bit is the sign only for signed operands
  assign half_a[HALF_W] = ctrl_i.signed_ab[0] & half_a[HALF_W-1];
  assign half_b[HALF_W] = ctrl_i.signed_ab[1] & half_b[HALF_W-1];

  // during the high-half steps the saved carry acts as bit 32
  assign acc = ctrl_i.carry_en ? {carry_i, op_c_i} : {op_c_i[DATA_W-1], op_c_i};

  //////////////////////////////
  // multiply and accumulate
  //////////////////////////////

  assign prod = $signed(half_a) * $signed(half_b);

  // rounding adds half an lsb of the shifted result, nothing for imm 0
  assign round_bit = DATA_W'(1) << ctrl_i.imm;
  assign round_val = round_i ? {1'b0, round_bit[DATA_W-1:1]} : '0;

  assign mac_o = $signed(acc) + $signed(prod) + $signed({1'b0, round_val});

  //////////////////////////////
  // shift
  //////////////////////////////

  // the 34-bit sum is only meaningful with the carry, else bit 31 is the sign
  assign msb_hi = ctrl_i.carry_en ? mac_o[DATA_W+1] : mac_o[DATA_W-1];
  assign msb_lo = ctrl_i.carry_en ? mac_o[DATA_W]   : mac_o[DATA_W-1];

  assign shift_in = {ctrl_i.shift_arith & msb_hi,
                     ctrl_i.shift_arith & msb_lo,
                     mac_o[DATA_W-1:0]};

  assign shifted  = $signed(shift_in) >>> ctrl_i.imm;
  assign result_o = shifted[DATA_W-1:0];

endmodule

/* verilog/simd_dot.sv */
// lane-parameterized SIMD dot product with accumulate

module simd_dot #(
  parameter int LANE_W = 16
) (
  input  logic [mult_pkg::DATA_W-1:0] op_a_i,
  input  logic [mult_pkg::DATA_W-1:0] op_b_i,
  input  logic [mult_pkg::DATA_W-1:0] op_c_i,
  input  logic [1:0]                  signed_i,
  output logic [mult_pkg::DATA_W-1:0] result_o
);
  import mult_pkg::*;

  localparam int N_LANES = DATA_W / LANE_W;
  localparam int PROD_W  = 2 * LANE_W + 2;

  logic [N_LANES-1:0][PROD_W-1:0] lane_prod;
  logic [DATA_W-1:0]              dot_sum;

  // per lane sign extension, bit 1 of signed_i for a and bit 0 for b
  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    logic [LANE_W:0] lane_a;
    logic [LANE_W:0] lane_b;

    assign lane_a = {signed_i[1] & op_a_i[i*LANE_W+LANE_W-1], op_a_i[i*LANE_W +: LANE_W]};
    assign lane_b = {signed_i[0] & op_b_i[i*LANE_W+LANE_W-1], op_b_i[i*LANE_W +: LANE_W]};

    assign lane_prod[i] = $signed(lane_a) * $signed(lane_b);
  end

  // adder tree left to synthesis, wraps modulo 2^32
  always_comb begin
    dot_sum = op_c_i;
    for (int i = 0; i < N_LANES; i++) begin
      dot_sum = dot_sum + DATA_W'($signed(lane_prod[i]));
    end
  end

  assign result_o = dot_sum;

endmodule
